// ==== bpm_result_top.f ====
+incdir+design
design/bpm_result_pkg.sv
design/result_if.sv
design/result_bank.sv
design/packet_framer.sv
design/slow_fifo.sv
design/bpm_result_top.sv
testbench/tb_bpm_result.sv

// ==== Bender.yml ====
package:
  name: bpm_result

sources:
  - include_dirs:
      - design
    files:
      - design/bpm_result_pkg.sv
      - design/result_if.sv
      - design/result_bank.sv
      - design/packet_framer.sv
      - design/slow_fifo.sv
      - design/bpm_result_top.sv
  - target: test
    files:
      - testbench/tb_bpm_result.sv

// ==== testbench/bpm_result_tests.txt ====
# E cal ovf pwr_a pwr_b pwr_c pwr_d x y s max_a max_b max_c max_d gain_a gain_b (all hex)
# P 16 packet words (hex), X fifo empty, R x y s (hex), C word count and W cycles (decimal)
X
C 0
R 0000 0000 0000
# one real event
E 0 0 00000a01 00000b01 00000c01 00000d01 1111 2222 3333 0aa1 0bb1 0cc1 0dd1 00010000 00020000
W 20
R 1111 2222 3333
C 16
P 4142504d 00010001 11112222 33330000 00000a01 00000b01 00000c01 00000d01
  0aa10bb1 0cc10dd1 00000000 00000000 00000000 00000000 00010000 00020000
X
# calibration event, no packet and real position kept
E 1 0 0000ca01 0000cb01 0000cc01 0000cd01 0c1a 0c1b 0c1c 0a02 0b02 0c02 0d02 00010000 00020000
W 20
X
R 1111 2222 3333
E 0 0 00000a03 00000b03 00000c03 00000d03 4444 5555 6666 0aa3 0bb3 0cc3 0dd3 00010000 00020000
W 20
R 4444 5555 6666
P 4142504d 00010002 44445555 66660000 00000a03 00000b03 00000c03 00000d03
  0aa30bb3 0cc30dd3 0c1a0c1b 00000000 0000ca01 0000cb01 00010000 00020000
X
# overflow A and C, new drift gains
E 0 a 00000a05 00000b05 00000c05 00000d05 7777 8888 9999 0aa5 0bb5 0cc5 0dd5 12345678 9abcdef0
W 20
P 4142504d a0010003 77778888 99990000 00000a05 00000b05 00000c05 00000d05
  0aa50bb5 0cc50dd5 0c1a0c1b 00000000 0000ca01 0000cb01 12345678 9abcdef0
X
# two packets fill to half full, the third event is dropped but counted
E 0 0 00000a07 00000b07 00000c07 00000d07 1234 5678 9abc 0aa7 0bb7 0cc7 0dd7 00010000 00020000
W 20
E 0 0 00000a09 00000b09 00000c09 00000d09 2345 6789 abcd 0aa9 0bb9 0cc9 0dd9 00010000 00020000
W 20
C 32
E 0 0 00000a0b 00000b0b 00000c0b 00000d0b 3456 789a bcde 0aab 0bbb 0ccb 0ddb 00010000 00020000
W 20
C 32
R 3456 789a bcde
P 4142504d 00010004 12345678 9abc0000 00000a07 00000b07 00000c07 00000d07
  0aa70bb7 0cc70dd7 0c1a0c1b 00000000 0000ca01 0000cb01 00010000 00020000
P 4142504d 00010005 23456789 abcd0000 00000a09 00000b09 00000c09 00000d09
  0aa90bb9 0cc90dd9 0c1a0c1b 00000000 0000ca01 0000cb01 00010000 00020000
X
C 0

// ==== testbench/tb_bpm_result.sv ====
`timescale 1ns/1ps

module tb_bpm_result;

	localparam TEST_FILE = "testbench/bpm_result_tests.txt";

	logic        clk;
	logic        RST_EVENT_NO;
	logic        run;
	logic [3:0]  overflow; // bit 3 is chan A
	logic        adj_rdy, cal_flag, position_rdy, max_valid;
	logic [31:0] power_a, power_b, power_c, power_d;
	logic [15:0] x, y, s;
	logic [15:0] max_a, max_b, max_c, max_d;
	logic [31:0] drift_gain_a, drift_gain_b;
	logic        sfifo_rd;
	logic [31:0] slow_fifo_dout;
	logic [5:0]  slow_fifo_wd;
	logic        slow_fifo_empty;
	logic [15:0] x_reg, y_reg, s_reg;

	int          errors = 0;
	int          checks = 0;
	int          cycles = 0;
	int          cycle_limit = 0; // zero until the test file is sized
	logic [31:0] rng = 32'd97162;
	integer      fd;

	bpm_result_top u_dut (.*);

	always #10 clk = ~clk; // 20 ns period

	// watchdog, limit follows the file length
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycle_limit > 0 && cycles > cycle_limit) begin
			$display("Timeout after %0d cycles, the test file did not finish", cycles);
			$display("%0d checks, %0d errors", checks, errors);
			$display("Simulation finished: FAIL");
			$finish;
		end
	end

	////////////////////////////////////////
	// helpers
	////////////////////////////////////////
	function automatic logic [31:0] xorshift(input logic [31:0] v);
		logic [31:0] r;
		r = v ^ (v << 13);
		r = r ^ (r >> 17);
		r = r ^ (r << 5);
		return r;
	endfunction

	// inputs change and outputs are sampled 2 ns past the edge
	task automatic next_cycle();
		@(posedge clk);
		#2;
	endtask

	task automatic expect_eq(input string name, input logic [31:0] want, input logic [31:0] got);
		checks++;
		if (got !== want) begin
			errors++;
			$display("Mismatch %s: expected 0x%08h, actual 0x%08h at %0t", name, want, got, $time);
		end
	endtask

	task automatic read_num(input bit dec, output logic [31:0] v);
		int r;
		r = dec ? $fscanf(fd, "%d", v) : $fscanf(fd, "%h", v);
		if (r != 1) begin
			errors++;
			v = '0;
			$display("Test file ended or broke off in the middle of a line");
		end
	endtask

	task automatic skip_line();
		int c;
		c = $fgetc(fd);
		while (c != 10 && c != -1)
			c = $fgetc(fd);
	endtask

	////////////////////////////////////////
	// one event, max then power then position
	////////////////////////////////////////
	task automatic apply_event();
		logic [31:0] f [15]; // cal ovf pwr*4 x y s max*4 gain*2
		for (int i = 0; i < 15; i++)
			read_num(0, f[i]);
		overflow     = f[1][3:0]; // held until the next event
		drift_gain_a = f[13];
		drift_gain_b = f[14];
		max_a        = f[9][15:0];
		max_b        = f[10][15:0];
		max_c        = f[11][15:0];
		max_d        = f[12][15:0];
		max_valid    = 1'b1;
		next_cycle();
		max_valid = 1'b0;
		cal_flag  = f[0][0];
		power_a   = f[2];
		power_b   = f[3];
		power_c   = f[4];
		power_d   = f[5];
		adj_rdy   = 1'b1;
		next_cycle();
		adj_rdy      = 1'b0;
		x            = f[6][15:0];
		y            = f[7][15:0];
		s            = f[8][15:0];
		position_rdy = 1'b1; // cal_flag still valid here
		next_cycle();
		position_rdy = 1'b0;
		cal_flag     = 1'b0;
	endtask

	// pop one packet, random gaps between reads
	task automatic pop_packet();
		logic [31:0] want [16];
		int          idle;
		for (int i = 0; i < 16; i++)
			read_num(0, want[i]);
		for (int i = 0; i < 16; i++) begin
			while (slow_fifo_empty)
				next_cycle();
			expect_eq($sformatf("slow_fifo_dout word %0d", i), want[i], slow_fifo_dout);
			sfifo_rd = 1'b1;
			next_cycle();
			sfifo_rd = 1'b0;
			rng  = xorshift(rng);
			idle = rng[1:0]; // 0 to 3 idle cycles
			repeat (idle) next_cycle();
		end
	endtask

	////////////////////////////////////////
	// main sequence
	////////////////////////////////////////
	initial begin : main
		int          c;
		int          n;
		int          r;
		logic [7:0]  op;
		logic [31:0] v0, v1, v2;
		clk          = 1'b0;
		RST_EVENT_NO = 1'b1;
		run          = 1'b1;
		overflow     = '0;
		adj_rdy      = 1'b0;
		cal_flag     = 1'b0;
		position_rdy = 1'b0;
		max_valid    = 1'b0;
		power_a      = '0;
		power_b      = '0;
		power_c      = '0;
		power_d      = '0;
		x            = '0;
		y            = '0;
		s            = '0;
		max_a        = '0;
		max_b        = '0;
		max_c        = '0;
		max_d        = '0;
		drift_gain_a = '0;
		drift_gain_b = '0;
		sfifo_rd     = 1'b0;

		// size the run from the line count
		fd = $fopen(TEST_FILE, "r");
		if (fd == 0) begin
			$display("Could not open the test file %s", TEST_FILE);
			$display("Simulation finished: FAIL");
			$finish;
		end
		n = 0;
		c = $fgetc(fd);
		while (c != -1) begin
			if (c == 10)
				n++;
			c = $fgetc(fd);
		end
		$fclose(fd);
		cycle_limit = 60 * n + 200;

		repeat (10) next_cycle(); // reset for 10 edges
		RST_EVENT_NO = 1'b0;

		fd = $fopen(TEST_FILE, "r");
		r  = $fscanf(fd, " %c", op);
		while (r == 1) begin
			case (op)
				"E": apply_event();
				"P": pop_packet();
				"X": expect_eq("slow_fifo_empty", 32'd1, slow_fifo_empty);
				"C": begin
					read_num(1, v0);
					expect_eq("slow_fifo_wd", v0, slow_fifo_wd);
				end
				"R": begin
					read_num(0, v0);
					read_num(0, v1);
					read_num(0, v2);
					expect_eq("x_reg", v0, x_reg);
					expect_eq("y_reg", v1, y_reg);
					expect_eq("s_reg", v2, s_reg);
				end
				"W": begin
					read_num(1, v0);
					repeat (v0) next_cycle();
				end
				"#": skip_line();
				default: begin
					errors++;
					$display("Unknown opcode '%c' in the test file", op);
					skip_line();
				end
			endcase
			r = $fscanf(fd, " %c", op);
		end
		$fclose(fd);

		if (checks == 0) begin
			errors++;
			$display("No checks were run, the test file held no check lines");
		end
		repeat (5) next_cycle();
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

// ==== design/bpm_result_top.sv ====
`timescale 1ns/1ps
`include "bpm_result_params.svh"

module bpm_result_top import bpm_result_pkg::*; (
	input  logic                   clk,
	input  logic                   RST_EVENT_NO,
	input  logic                   run,
	input  logic [3:0]             overflow,
	input  logic                   adj_rdy,
	input  logic                   cal_flag,
	input  logic                   position_rdy,
	input  logic                   max_valid,
	input  logic [`SF_WIDTH-1:0]   power_a,
	input  logic [`SF_WIDTH-1:0]   power_b,
	input  logic [`SF_WIDTH-1:0]   power_c,
	input  logic [`SF_WIDTH-1:0]   power_d,
	input  logic [`DATA_WIDTH-1:0] x,
	input  logic [`DATA_WIDTH-1:0] y,
	input  logic [`DATA_WIDTH-1:0] s,
	input  logic [`DATA_WIDTH-1:0] max_a,
	input  logic [`DATA_WIDTH-1:0] max_b,
	input  logic [`DATA_WIDTH-1:0] max_c,
	input  logic [`DATA_WIDTH-1:0] max_d,
	input  logic [`SF_WIDTH-1:0]   drift_gain_a,
	input  logic [`SF_WIDTH-1:0]   drift_gain_b,
	input  logic                   sfifo_rd,
	output logic [31:0]            slow_fifo_dout,
	output logic [`SFIFO_AW:0]     slow_fifo_wd,
	output logic                   slow_fifo_empty,
	output logic [`DATA_WIDTH-1:0] x_reg,
	output logic [`DATA_WIDTH-1:0] y_reg,
	output logic [`DATA_WIDTH-1:0] s_reg
);

	chan_pwr_t power_arr;
	chan_val_t max_arr;
	logic      fifo_wr;
	pkt_word_u fifo_din;
	logic      fifo_full;
	logic      fifo_half_full;

	result_if res_bus ();

	// chan A lands at index 0
	assign power_arr = {power_d, power_c, power_b, power_a};
	assign max_arr   = {max_d, max_c, max_b, max_a};

	result_bank u_bank (
		.clk(clk), .RST_EVENT_NO(RST_EVENT_NO), .run(run), .overflow(overflow),
		.adj_rdy(adj_rdy), .cal_flag(cal_flag), .position_rdy(position_rdy),
		.max_valid(max_valid), .fifo_full(fifo_full), .power(power_arr),
		.x(x), .y(y), .s(s), .max_in(max_arr), .res(res_bus)
	);

	packet_framer u_framer (
		.clk(clk), .RST_EVENT_NO(RST_EVENT_NO), .res(res_bus),
		.drift_gain_a(drift_gain_a), .drift_gain_b(drift_gain_b),
		.fifo_half_full(fifo_half_full), .fifo_wr(fifo_wr), .fifo_din(fifo_din)
	);

	slow_fifo u_sfifo (
		.clk(clk), .RST_EVENT_NO(RST_EVENT_NO), .wr(fifo_wr), .din(fifo_din),
		.rd(sfifo_rd), .dout(slow_fifo_dout), .empty(slow_fifo_empty),
		.full(fifo_full), .half_full(fifo_half_full), .count(slow_fifo_wd)
	);

	// real position for the host display
	assign x_reg = res_bus.x_reg;
	assign y_reg = res_bus.y_reg;
	assign s_reg = res_bus.s_reg;

endmodule

// ==== design/slow_fifo.sv ====
`timescale 1ns/1ps
`include "bpm_result_params.svh"

module slow_fifo import bpm_result_pkg::*; (
	input  logic              clk,
	input  logic              RST_EVENT_NO,
	input  logic              wr,
	input  pkt_word_u         din,
	input  logic              rd,
	output logic [31:0]       dout,
	output logic              empty,
	output logic              full,
	output logic              half_full,
	output logic [`SFIFO_AW:0] count
);

	logic [31:0]          mem [`SFIFO_DEPTH];
	logic [`SFIFO_AW-1:0] wr_ptr;
	logic [`SFIFO_AW-1:0] rd_ptr;
	logic                 do_wr;
	logic                 do_rd;

	assign do_wr = wr && !full;  // write while full dropped
	assign do_rd = rd && !empty; // read while empty ignored

	////////////////////////////////////////
	// storage
	////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (do_wr)
			mem[wr_ptr] <= din.word;
	end

	// pointers wrap naturally at depth
	always_ff @(posedge clk) begin
		if (RST_EVENT_NO) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_wr)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_wr, do_rd})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count; // both or neither
			endcase
		end
	end

	assign dout      = mem[rd_ptr]; // head word, fall through
	assign empty     = (count == '0);
	assign full      = (count == (`SFIFO_AW+1)'(`SFIFO_DEPTH));
	assign half_full = (count > (`SFIFO_AW+1)'(`SFIFO_DEPTH / 2)); // one more packet fits at half

	// framer holds off at half full, so a full fifo never sees a write
	a_no_wr_full : assert property (
		@(posedge clk) disable iff (RST_EVENT_NO)
		wr |-> !full
	) else $error("slow fifo written while full");

endmodule

// ==== design/packet_framer.sv ====
`timescale 1ns/1ps
`include "bpm_result_params.svh"

module packet_framer import bpm_result_pkg::*; (
	input  logic                 clk,
	input  logic                 RST_EVENT_NO,
	result_if.framer             res,
	input  logic [`SF_WIDTH-1:0] drift_gain_a,
	input  logic [`SF_WIDTH-1:0] drift_gain_b,
	input  logic                 fifo_half_full,
	output logic                 fifo_wr,
	output pkt_word_u            fifo_din
);

	// word states 0..15 carry their word number, idle sits above
	localparam logic [4:0] ST_LAST = 5'(`PKT_WORDS - 1);
	localparam logic [4:0] ST_IDLE = 5'(`PKT_WORDS);

	logic [4:0] state;

	////////////////////////////////////////
	// state sequence
	////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (RST_EVENT_NO) begin
			state <= ST_IDLE;
		end else begin
			case (state)
				ST_IDLE: begin
					if (res.event_done && !fifo_half_full) // drop whole packet otherwise
						state <= 5'd0;
				end
				ST_LAST: state <= ST_IDLE;
				default: begin
					if (state < ST_LAST)
						state <= state + 5'd1;
					else
						state <= ST_IDLE; // unused codes
				end
			endcase
		end
	end

	assign fifo_wr = (state <= ST_LAST); // one word per word state

	////////////////////////////////////////
	// packet word select
	////////////////////////////////////////
	always_comb begin
		fifo_din = '0;
		if (fifo_wr) begin
			case (state[3:0])
				4'd0:  fifo_din.word = `PKT_ID;
				4'd1:  begin fifo_din.half.hi = res.status;     fifo_din.half.lo = res.evt_cnt;    end
				4'd2:  begin fifo_din.half.hi = res.x_reg;      fifo_din.half.lo = res.y_reg;      end
				4'd3:  fifo_din.half.hi = res.s_reg;            // low half stays zero
				4'd4:  fifo_din.word = res.pwr_real[0];
				4'd5:  fifo_din.word = res.pwr_real[1];
				4'd6:  fifo_din.word = res.pwr_real[2];
				4'd7:  fifo_din.word = res.pwr_real[3];
				4'd8:  begin fifo_din.half.hi = res.max_reg[0]; fifo_din.half.lo = res.max_reg[1]; end
				4'd9:  begin fifo_din.half.hi = res.max_reg[2]; fifo_din.half.lo = res.max_reg[3]; end
				4'd10: begin fifo_din.half.hi = res.x_cal;      fifo_din.half.lo = res.y_cal;      end
				4'd11: fifo_din.word = '0; // spare word
				4'd12: fifo_din.word = res.pwr_cal_a;
				4'd13: fifo_din.word = res.pwr_cal_b;
				4'd14: fifo_din.word = drift_gain_a;
				default: fifo_din.word = drift_gain_b; // word 15
			endcase
		end
	end

	// whole packets only, never a partial burst
	a_full_burst : assert property (
		@(posedge clk) disable iff (RST_EVENT_NO)
		$rose(fifo_wr) |-> fifo_wr [*`PKT_WORDS] ##1 !fifo_wr
	) else $error("fifo_wr burst length is not one packet");

endmodule

// ==== design/result_bank.sv ====
`timescale 1ns/1ps
`include "bpm_result_params.svh"

module result_bank import bpm_result_pkg::*; (
	input  logic                   clk,
	input  logic                   RST_EVENT_NO,
	input  logic                   run,
	input  logic [3:0]             overflow, // bit 3 is chan A
	input  logic                   adj_rdy,
	input  logic                   cal_flag,
	input  logic                   position_rdy,
	input  logic                   max_valid,
	input  logic                   fifo_full,
	input  chan_pwr_t              power,
	input  logic [`DATA_WIDTH-1:0] x,
	input  logic [`DATA_WIDTH-1:0] y,
	input  logic [`DATA_WIDTH-1:0] s,
	input  chan_val_t              max_in,
	result_if.bank                 res
);

	////////////////////////////////////////
	// power capture and event count
	////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (RST_EVENT_NO) begin
			res.pwr_real  <= '0;
			res.pwr_cal_a <= '0;
			res.pwr_cal_b <= '0;
			res.evt_cnt   <= '0;
		end else if (adj_rdy) begin
			if (cal_flag) begin
				res.pwr_cal_a <= power[0]; // only A and B go into the packet
				res.pwr_cal_b <= power[1];
			end else begin
				res.pwr_real <= power;
				res.evt_cnt  <= res.evt_cnt + 1'b1; // real events only
			end
		end
	end

	////////////////////////////////////////
	// position capture
	////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (RST_EVENT_NO) begin
			res.x_reg      <= '0;
			res.y_reg      <= '0;
			res.s_reg      <= '0;
			res.x_cal      <= '0;
			res.y_cal      <= '0;
			res.event_done <= 1'b0;
		end else begin
			res.event_done <= position_rdy && !cal_flag; // same cycle the regs update
			if (position_rdy && !cal_flag) begin
				res.x_reg <= x;
				res.y_reg <= y;
				res.s_reg <= s;
			end else if (position_rdy) begin
				res.x_cal <= x; // cal sum not kept
				res.y_cal <= y;
			end
		end
	end

	// channel maxima, no real/cal split
	always_ff @(posedge clk) begin
		if (RST_EVENT_NO) begin
			res.max_reg <= '0;
		end else if (max_valid) begin
			res.max_reg <= max_in;
		end
	end

	// overflow A..D, spare, fifo full, run
	assign res.status = {overflow, 10'b0, fifo_full, run};

	// power and position results come from one pipeline, never together
	a_rdy_exclusive : assert property (
		@(posedge clk) disable iff (RST_EVENT_NO)
		!(adj_rdy && position_rdy)
	) else $error("adj_rdy and position_rdy high in the same cycle");

endmodule

// ==== design/result_if.sv ====
`timescale 1ns/1ps
`include "bpm_result_params.svh"

// captured event results, bank side drives everything
interface result_if import bpm_result_pkg::*; ();

	logic                   event_done; // one clk wide, real event only
	logic [`DATA_WIDTH-1:0] evt_cnt;
	logic [`DATA_WIDTH-1:0] status;

	// real event position
	logic [`DATA_WIDTH-1:0] x_reg;
	logic [`DATA_WIDTH-1:0] y_reg;
	logic [`DATA_WIDTH-1:0] s_reg;

	// calibration position, no sum kept
	logic [`DATA_WIDTH-1:0] x_cal;
	logic [`DATA_WIDTH-1:0] y_cal;

	chan_pwr_t              pwr_real;
	logic [`SF_WIDTH-1:0]   pwr_cal_a;
	logic [`SF_WIDTH-1:0]   pwr_cal_b;
	chan_val_t              max_reg;

	modport bank (
		output event_done, evt_cnt, status, x_reg, y_reg, s_reg,
		output x_cal, y_cal, pwr_real, pwr_cal_a, pwr_cal_b, max_reg
	);

	modport framer (
		input event_done, evt_cnt, status, x_reg, y_reg, s_reg,
		input x_cal, y_cal, pwr_real, pwr_cal_a, pwr_cal_b, max_reg
	);

endinterface

// ==== design/bpm_result_pkg.sv ====
`include "bpm_result_params.svh"

package bpm_result_pkg;

	////////////////////////////////////////
	// packet word views
	////////////////////////////////////////

	// high half goes out first on the host side
	typedef struct packed {
		logic [`DATA_WIDTH-1:0] hi;
		logic [`DATA_WIDTH-1:0] lo;
	} pkt_halves_t;

	typedef union packed {
		logic [2*`DATA_WIDTH-1:0] word; // full 32 bit view, power and gain words
		pkt_halves_t              half; // paired 16 bit values
	} pkt_word_u;

	////////////////////////////////////////
	// per channel arrays, index 0 is chan A
	////////////////////////////////////////
	typedef logic [3:0][`SF_WIDTH-1:0]   chan_pwr_t;
	typedef logic [3:0][`DATA_WIDTH-1:0] chan_val_t;

endpackage

// ==== design/bpm_result_params.svh ====
`ifndef BPM_RESULT_PARAMS_SVH
`define BPM_RESULT_PARAMS_SVH

// position, maxima and status values
`define DATA_WIDTH 16

// fixed point power and gain words
`define SF_WIDTH 32

// packet framing
`define PKT_WORDS 16
`define PKT_ID 32'h4142504D // ascii ABPM

// slow fifo geometry
`define SFIFO_DEPTH 32
`define SFIFO_AW 5 // count is one bit wider

`endif
